// File: dual_capture_top.f
+incdir+rtl
rtl/capture_pkg.sv
rtl/dualport_ram_async.sv
rtl/async_fifo.sv
rtl/fifo_drain_master.sv
rtl/wb_arbiter.sv
rtl/sample_buffer_ram.sv
rtl/dual_capture_top.sv
testbench/tb_clock_gen.sv
testbench/dual_capture_tb.sv

// File: rtl/async_fifo.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module async_fifo #(
  parameter int FIFO_DEPTH = `CAP_FIFO_DEPTH,
  parameter int FIFO_AFULL = `CAP_FIFO_AFULL
) (
  input  logic                   wr_clk,
  input  logic                   wr_rst_n,
  input  logic                   wr_en,
  input  capture_pkg::cap_data_t wr_data,
  output logic                   full,
  output logic                   afull,
  input  logic                   rd_clk,
  input  logic                   rd_rst_n,
  input  logic                   rd_en,
  output capture_pkg::cap_data_t rd_data,
  output logic                   empty
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  logic [ADDR_WIDTH:0] wr_bin;
  logic [ADDR_WIDTH:0] wr_bin_nxt;
  logic [ADDR_WIDTH:0] wr_gray;
  logic [ADDR_WIDTH:0] wr_gray_nxt;
  logic [ADDR_WIDTH:0] rd_bin;
  logic [ADDR_WIDTH:0] rd_bin_nxt;
  logic [ADDR_WIDTH:0] rd_gray;
  logic [ADDR_WIDTH:0] rd_gray_nxt;
  logic [ADDR_WIDTH:0] rd_gray_wsync1;
  logic [ADDR_WIDTH:0] rd_gray_wsync2;
  logic [ADDR_WIDTH:0] wr_gray_rsync1;
  logic [ADDR_WIDTH:0] wr_gray_rsync2;
  logic [ADDR_WIDTH:0] rd_bin_wsync;
  logic [ADDR_WIDTH:0] wr_fill;
  logic                wr_vld;
  logic                rd_vld;

  function automatic logic [ADDR_WIDTH:0] gray2bin(input logic [ADDR_WIDTH:0] g);
    logic [ADDR_WIDTH:0] b;
    b[ADDR_WIDTH] = g[ADDR_WIDTH];
    for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  assign wr_vld = wr_en && !full; // writes while full are dropped.
  assign rd_vld = rd_en && !empty;

  dualport_ram_async #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_ram (
    .wr_clk  (wr_clk),
    .wr_en   (wr_vld),
    .wr_addr (wr_bin[ADDR_WIDTH-1:0]),
    .wr_data (wr_data),
    .rd_clk  (rd_clk),
    .rd_rst_n(rd_rst_n),
    .rd_en   (rd_vld),
    .rd_addr (rd_bin[ADDR_WIDTH-1:0]),
    .rd_data (rd_data)
  );

  assign wr_bin_nxt   = wr_bin + {{ADDR_WIDTH{1'b0}}, wr_vld};
  assign wr_gray_nxt  = (wr_bin_nxt >> 1) ^ wr_bin_nxt;
  assign rd_bin_wsync = gray2bin(rd_gray_wsync2);
  assign wr_fill      = wr_bin_nxt - rd_bin_wsync;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin         <= '0;
      wr_gray        <= '0;
      rd_gray_wsync1 <= '0;
      rd_gray_wsync2 <= '0;
      full           <= 1'b0;
      afull          <= 1'b0;
    end else begin
      wr_bin         <= wr_bin_nxt;
      wr_gray        <= wr_gray_nxt;
      rd_gray_wsync1 <= rd_gray;
      rd_gray_wsync2 <= rd_gray_wsync1;
      full  <= (wr_gray_nxt == {~rd_gray_wsync2[ADDR_WIDTH:ADDR_WIDTH-1],
                                rd_gray_wsync2[ADDR_WIDTH-2:0]});
      afull <= (wr_fill >= (ADDR_WIDTH+1)'(FIFO_AFULL));
    end
  end

  assign rd_bin_nxt  = rd_bin + {{ADDR_WIDTH{1'b0}}, rd_vld};
  assign rd_gray_nxt = (rd_bin_nxt >> 1) ^ rd_bin_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin         <= '0;
      rd_gray        <= '0;
      wr_gray_rsync1 <= '0;
      wr_gray_rsync2 <= '0;
      empty          <= 1'b1;
    end else begin
      rd_bin         <= rd_bin_nxt;
      rd_gray        <= rd_gray_nxt;
      wr_gray_rsync1 <= wr_gray;
      wr_gray_rsync2 <= wr_gray_rsync1;
      empty          <= (rd_gray_nxt == wr_gray_rsync2);
    end
  end

endmodule

// File: rtl/capture_defs.svh
`ifndef CAPTURE_DEFS_SVH
`define CAPTURE_DEFS_SVH

// sample width in bits.
`define CAP_DATA_WIDTH 16

// FIFO depth in words and the fill level that raises afull.
`define CAP_FIFO_DEPTH 16
`define CAP_FIFO_AFULL 15

// sample buffer, 64 words shared by two channels.
`define CAP_BUF_ADDR_WIDTH 6
`define CAP_BUF_WORDS 64

// offset within one 32-word channel region.
`define CAP_CHAN_ADDR_WIDTH 5

`endif

// File: rtl/capture_pkg.sv
`include "capture_defs.svh"

package capture_pkg;

  // one captured sample.
  typedef logic [`CAP_DATA_WIDTH-1:0] cap_data_t;

  // word address into the sample buffer.
  typedef logic [`CAP_BUF_ADDR_WIDTH-1:0] buf_addr_t;

  // write offset inside a channel region.
  typedef logic [`CAP_CHAN_ADDR_WIDTH-1:0] chan_offset_t;

  // arbiter grant index: 0 = drain 0, 1 = drain 1, 2 = host.
  typedef logic [1:0] master_idx_t;

  typedef enum logic [1:0] {
    IDLE,
    POP,
    WRITE
  } drain_state_t;

endpackage

// File: rtl/dual_capture_top.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module dual_capture_top (
  input  logic                   wr0_clk,
  input  logic                   wr1_clk,
  input  logic                   wr_rst_n,
  input  logic                   wr0_en,
  input  capture_pkg::cap_data_t wr0_data,
  output logic                   wr0_full,
  output logic                   wr0_afull,
  input  logic                   wr1_en,
  input  capture_pkg::cap_data_t wr1_data,
  output logic                   wr1_full,
  output logic                   wr1_afull,
  input  logic                   rd_clk,
  input  logic                   rd_rst_n,
  input  logic [1:0]             drain_en,
  output logic [1:0]             chan_idle,
  input  logic                   host_cyc,
  input  logic                   host_stb,
  input  logic                   host_we,
  input  capture_pkg::buf_addr_t host_adr,
  input  capture_pkg::cap_data_t host_dat_w,
  output capture_pkg::cap_data_t host_dat_r,
  output logic                   host_ack
);

  logic [1:0]             fifo_empty;
  logic [1:0]             fifo_rd_en;
  capture_pkg::cap_data_t fifo_rd_data [2];
  logic [1:0]             d_cyc;
  logic [1:0]             d_stb;
  logic [1:0]             d_we;
  capture_pkg::buf_addr_t d_adr [2];
  capture_pkg::cap_data_t d_dat_w [2];
  logic [1:0]             d_ack;
  logic                   s_cyc;
  logic                   s_stb;
  logic                   s_we;
  capture_pkg::buf_addr_t s_adr;
  capture_pkg::cap_data_t s_dat_w;
  capture_pkg::cap_data_t s_dat_r;
  logic                   s_ack;

  async_fifo u_fifo0 (
    .wr_clk(wr0_clk), .wr_rst_n(wr_rst_n), .wr_en(wr0_en), .wr_data(wr0_data),
    .full(wr0_full), .afull(wr0_afull), .rd_clk(rd_clk), .rd_rst_n(rd_rst_n),
    .rd_en(fifo_rd_en[0]), .rd_data(fifo_rd_data[0]), .empty(fifo_empty[0])
  );

  async_fifo u_fifo1 (
    .wr_clk(wr1_clk), .wr_rst_n(wr_rst_n), .wr_en(wr1_en), .wr_data(wr1_data),
    .full(wr1_full), .afull(wr1_afull), .rd_clk(rd_clk), .rd_rst_n(rd_rst_n),
    .rd_en(fifo_rd_en[1]), .rd_data(fifo_rd_data[1]), .empty(fifo_empty[1])
  );

  fifo_drain_master #(.CHAN_BASE(capture_pkg::buf_addr_t'(0))) u_drain0 (
    .rd_clk(rd_clk), .rd_rst_n(rd_rst_n), .drain_en(drain_en[0]),
    .fifo_empty(fifo_empty[0]), .fifo_rd_en(fifo_rd_en[0]),
    .fifo_rd_data(fifo_rd_data[0]), .wb_cyc(d_cyc[0]), .wb_stb(d_stb[0]),
    .wb_we(d_we[0]), .wb_adr(d_adr[0]), .wb_dat_w(d_dat_w[0]),
    .wb_ack(d_ack[0]), .idle(chan_idle[0])
  );

  fifo_drain_master #(
    .CHAN_BASE(capture_pkg::buf_addr_t'(1 << `CAP_CHAN_ADDR_WIDTH)) // upper region.
  ) u_drain1 (
    .rd_clk(rd_clk), .rd_rst_n(rd_rst_n), .drain_en(drain_en[1]),
    .fifo_empty(fifo_empty[1]), .fifo_rd_en(fifo_rd_en[1]),
    .fifo_rd_data(fifo_rd_data[1]), .wb_cyc(d_cyc[1]), .wb_stb(d_stb[1]),
    .wb_we(d_we[1]), .wb_adr(d_adr[1]), .wb_dat_w(d_dat_w[1]),
    .wb_ack(d_ack[1]), .idle(chan_idle[1])
  );

  wb_arbiter u_arb (
    .rd_clk(rd_clk), .rd_rst_n(rd_rst_n),
    .m0_cyc(d_cyc[0]), .m0_stb(d_stb[0]), .m0_we(d_we[0]), .m0_adr(d_adr[0]),
    .m0_dat_w(d_dat_w[0]), .m0_dat_r(), .m0_ack(d_ack[0]),
    .m1_cyc(d_cyc[1]), .m1_stb(d_stb[1]), .m1_we(d_we[1]), .m1_adr(d_adr[1]),
    .m1_dat_w(d_dat_w[1]), .m1_dat_r(), .m1_ack(d_ack[1]),
    .m2_cyc(host_cyc), .m2_stb(host_stb), .m2_we(host_we), .m2_adr(host_adr),
    .m2_dat_w(host_dat_w), .m2_dat_r(host_dat_r), .m2_ack(host_ack),
    .s_cyc(s_cyc), .s_stb(s_stb), .s_we(s_we), .s_adr(s_adr),
    .s_dat_w(s_dat_w), .s_dat_r(s_dat_r), .s_ack(s_ack)
  );

  sample_buffer_ram u_buf (
    .rd_clk(rd_clk), .rd_rst_n(rd_rst_n), .wb_cyc(s_cyc), .wb_stb(s_stb),
    .wb_we(s_we), .wb_adr(s_adr), .wb_dat_w(s_dat_w), .wb_dat_r(s_dat_r),
    .wb_ack(s_ack)
  );

endmodule

// File: rtl/dualport_ram_async.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module dualport_ram_async #(
  parameter int ADDR_WIDTH = $clog2(`CAP_FIFO_DEPTH)
) (
  input  logic                   wr_clk,
  input  logic                   wr_en,
  input  logic [ADDR_WIDTH-1:0]  wr_addr,
  input  capture_pkg::cap_data_t wr_data,
  input  logic                   rd_clk,
  input  logic                   rd_rst_n,
  input  logic                   rd_en,
  input  logic [ADDR_WIDTH-1:0]  rd_addr,
  output capture_pkg::cap_data_t rd_data
);

  capture_pkg::cap_data_t mem [0:(1<<ADDR_WIDTH)-1];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr]; // valid the cycle after rd_en.
    end
  end

endmodule

// File: rtl/fifo_drain_master.sv
`timescale 1ns/1ps

module fifo_drain_master #(
  parameter capture_pkg::buf_addr_t CHAN_BASE = '0
) (
  input  logic                   rd_clk,
  input  logic                   rd_rst_n,
  input  logic                   drain_en,
  input  logic                   fifo_empty,
  output logic                   fifo_rd_en,
  input  capture_pkg::cap_data_t fifo_rd_data,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output capture_pkg::buf_addr_t wb_adr,
  output capture_pkg::cap_data_t wb_dat_w,
  input  logic                   wb_ack,
  output logic                   idle
);

  capture_pkg::drain_state_t state;
  capture_pkg::drain_state_t state_nxt;
  capture_pkg::chan_offset_t offset;
  capture_pkg::cap_data_t    sample_q;

  // a pop starts only from IDLE, so a paused engine finishes its write first.
  assign fifo_rd_en = (state == capture_pkg::IDLE) && drain_en && !fifo_empty;

  always_comb begin
    state_nxt = state;
    case (state)
      capture_pkg::IDLE: begin
        if (fifo_rd_en) begin
          state_nxt = capture_pkg::POP;
        end
      end
      capture_pkg::POP: begin
        state_nxt = capture_pkg::WRITE; // ram data lands this cycle.
      end
      capture_pkg::WRITE: begin
        if (wb_ack) begin
          state_nxt = capture_pkg::IDLE;
        end
      end
      default: begin
        state_nxt = capture_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      state  <= capture_pkg::IDLE;
      offset <= '0;
    end else begin
      state <= state_nxt;
      if (state == capture_pkg::WRITE && wb_ack) begin
        offset <= offset + 1'b1; // wraps inside the 32-word region.
      end
    end
  end

  always_ff @(posedge rd_clk) begin
    if (state == capture_pkg::POP) begin
      sample_q <= fifo_rd_data;
    end
  end

  assign wb_cyc   = (state == capture_pkg::WRITE);
  assign wb_stb   = (state == capture_pkg::WRITE);
  assign wb_we    = (state == capture_pkg::WRITE);
  assign wb_adr   = CHAN_BASE + capture_pkg::buf_addr_t'(offset);
  assign wb_dat_w = sample_q;

  assign idle = (state == capture_pkg::IDLE) && fifo_empty;

endmodule

// File: rtl/sample_buffer_ram.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module sample_buffer_ram (
  input  logic                   rd_clk,
  input  logic                   rd_rst_n,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  capture_pkg::buf_addr_t wb_adr,
  input  capture_pkg::cap_data_t wb_dat_w,
  output capture_pkg::cap_data_t wb_dat_r,
  output logic                   wb_ack
);

  capture_pkg::cap_data_t mem [0:`CAP_BUF_WORDS-1];
  logic                   req_new;

  // ack drops for a cycle after each transfer.
  assign req_new = wb_cyc && wb_stb && !wb_ack;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req_new;
    end
  end

  always_ff @(posedge rd_clk) begin
    if (req_new) begin
      if (wb_we) begin
        mem[wb_adr] <= wb_dat_w;
      end
      wb_dat_r <= mem[wb_adr]; // lines up with ack.
    end
  end

endmodule

// File: rtl/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
  input  logic                   rd_clk,
  input  logic                   rd_rst_n,
  input  logic                   m0_cyc,
  input  logic                   m0_stb,
  input  logic                   m0_we,
  input  capture_pkg::buf_addr_t m0_adr,
  input  capture_pkg::cap_data_t m0_dat_w,
  output capture_pkg::cap_data_t m0_dat_r,
  output logic                   m0_ack,
  input  logic                   m1_cyc,
  input  logic                   m1_stb,
  input  logic                   m1_we,
  input  capture_pkg::buf_addr_t m1_adr,
  input  capture_pkg::cap_data_t m1_dat_w,
  output capture_pkg::cap_data_t m1_dat_r,
  output logic                   m1_ack,
  input  logic                   m2_cyc,
  input  logic                   m2_stb,
  input  logic                   m2_we,
  input  capture_pkg::buf_addr_t m2_adr,
  input  capture_pkg::cap_data_t m2_dat_w,
  output capture_pkg::cap_data_t m2_dat_r,
  output logic                   m2_ack,
  output logic                   s_cyc,
  output logic                   s_stb,
  output logic                   s_we,
  output capture_pkg::buf_addr_t s_adr,
  output capture_pkg::cap_data_t s_dat_w,
  input  capture_pkg::cap_data_t s_dat_r,
  input  logic                   s_ack
);

  capture_pkg::master_idx_t grant;
  capture_pkg::master_idx_t pick;
  capture_pkg::master_idx_t sel;
  logic                     busy;
  logic [2:0]               req;

  assign req = {m2_cyc, m1_cyc, m0_cyc};

  // next requester after the last grant.
  always_comb begin
    pick = grant;
    case (grant)
      2'd0:    pick = req[1] ? 2'd1 : req[2] ? 2'd2 : req[0] ? 2'd0 : grant;
      2'd1:    pick = req[2] ? 2'd2 : req[0] ? 2'd0 : req[1] ? 2'd1 : grant;
      default: pick = req[0] ? 2'd0 : req[1] ? 2'd1 : req[2] ? 2'd2 : grant;
    endcase
  end

  assign sel = busy ? grant : pick; // a free bus routes the winner at once.

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      grant <= 2'd2; // drain 0 wins the first round.
      busy  <= 1'b0;
    end else if (!busy) begin
      if (|req) begin
        grant <= pick;
        busy  <= 1'b1;
      end
    end else if (!req[grant]) begin
      busy <= 1'b0;
    end
  end

  always_comb begin
    case (sel)
      2'd0: begin
        s_cyc   = m0_cyc;
        s_stb   = m0_stb;
        s_we    = m0_we;
        s_adr   = m0_adr;
        s_dat_w = m0_dat_w;
      end
      2'd1: begin
        s_cyc   = m1_cyc;
        s_stb   = m1_stb;
        s_we    = m1_we;
        s_adr   = m1_adr;
        s_dat_w = m1_dat_w;
      end
      default: begin
        s_cyc   = m2_cyc;
        s_stb   = m2_stb;
        s_we    = m2_we;
        s_adr   = m2_adr;
        s_dat_w = m2_dat_w;
      end
    endcase
  end

  assign m0_ack   = s_ack && (sel == 2'd0);
  assign m1_ack   = s_ack && (sel == 2'd1);
  assign m2_ack   = s_ack && (sel == 2'd2);
  assign m0_dat_r = (sel == 2'd0) ? s_dat_r : '0;
  assign m1_dat_r = (sel == 2'd1) ? s_dat_r : '0;
  assign m2_dat_r = (sel == 2'd2) ? s_dat_r : '0;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f dual_capture_top.f \
  --top-module dual_capture_tb -o dual_capture_sim \
  && out="$(./obj_dir/dual_capture_sim)" \
  && echo "$out" \
  && grep -q "TEST RESULT: PASS" <<< "$out" \
  && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }

// File: testbench/dual_capture_tb.sv
`timescale 1ns/1ps
`include "capture_defs.svh"

module dual_capture_tb;

  localparam int TIMEOUT_CYCLES = 20000; // about 300 pushes and reads with margin.
  localparam int ACK_LIMIT = 32; // rd_clk cycles a host access may wait for grant and ack.
  localparam int REGION = 1 << `CAP_CHAN_ADDR_WIDTH;

  logic                      rd_clk;
  logic                      wr_clk;
  logic                      rd_rst_n;
  logic                      wr_rst_n;
  logic                      wr0_en;
  logic                      wr1_en;
  capture_pkg::cap_data_t    wr0_data;
  capture_pkg::cap_data_t    wr1_data;
  logic                      wr0_full;
  logic                      wr0_afull;
  logic                      wr1_full;
  logic                      wr1_afull;
  logic [1:0]                drain_en;
  logic [1:0]                chan_idle;
  logic                      host_cyc;
  logic                      host_stb;
  logic                      host_we;
  capture_pkg::buf_addr_t    host_adr;
  capture_pkg::cap_data_t    host_dat_w;
  capture_pkg::cap_data_t    host_dat_r;
  logic                      host_ack;
  capture_pkg::cap_data_t    model [0:`CAP_BUF_WORDS-1];
  logic                      written [0:`CAP_BUF_WORDS-1];
  capture_pkg::chan_offset_t exp_off [2];
  logic [15:0]               lfsr;
  int                        errors;
  int                        checks;
  int                        cycles = 0;

  tb_clock_gen u_clk (
    .rd_clk(rd_clk), .wr_clk(wr_clk), .rd_rst_n(rd_rst_n), .wr_rst_n(wr_rst_n)
  );

  dual_capture_top uut (
    .wr0_clk(wr_clk), .wr1_clk(wr_clk), .wr_rst_n(wr_rst_n),
    .wr0_en(wr0_en), .wr0_data(wr0_data), .wr0_full(wr0_full), .wr0_afull(wr0_afull),
    .wr1_en(wr1_en), .wr1_data(wr1_data), .wr1_full(wr1_full), .wr1_afull(wr1_afull),
    .rd_clk(rd_clk), .rd_rst_n(rd_rst_n), .drain_en(drain_en), .chan_idle(chan_idle),
    .host_cyc(host_cyc), .host_stb(host_stb), .host_we(host_we), .host_adr(host_adr),
    .host_dat_w(host_dat_w), .host_dat_r(host_dat_r), .host_ack(host_ack)
  );

  always @(posedge rd_clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d rd_clk cycles", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // 16-bit Galois LFSR, one step per bit taken.
  function automatic capture_pkg::cap_data_t next_sample();
    capture_pkg::cap_data_t v;
    for (int i = 0; i < 16; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic expect_word(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic push(input int ch, input capture_pkg::cap_data_t data, input bit retry,
                      output bit accepted);
    do begin
      @(negedge wr_clk);
      accepted = (ch == 0) ? !wr0_full : !wr1_full; // full is stable until the next edge.
      if (ch == 0) begin
        wr0_en   = 1'b1;
        wr0_data = data;
      end else begin
        wr1_en   = 1'b1;
        wr1_data = data;
      end
      @(negedge wr_clk);
      if (ch == 0) begin
        wr0_en = 1'b0;
      end else begin
        wr1_en = 1'b0;
      end
    end while (retry && !accepted);
    if (accepted) begin
      model[ch * REGION + int'(exp_off[ch])]   = data;
      written[ch * REGION + int'(exp_off[ch])] = 1'b1;
      exp_off[ch]++; // wraps inside the region.
    end
  endtask

  task automatic wait_host_ack(input string op, input capture_pkg::buf_addr_t adr);
    int waited;
    waited = 0;
    @(negedge rd_clk);
    while (!host_ack && waited < ACK_LIMIT) begin
      @(negedge rd_clk);
      waited++;
    end
    checks++;
    if (!host_ack) begin
      errors++;
      $display("host %s at address %0d was never acknowledged", op, adr);
    end
  endtask

  task automatic host_read(input capture_pkg::buf_addr_t adr,
                           output capture_pkg::cap_data_t data);
    @(negedge rd_clk);
    host_cyc = 1'b1;
    host_stb = 1'b1;
    host_we  = 1'b0;
    host_adr = adr;
    wait_host_ack("read", adr);
    data     = host_dat_r;
    host_cyc = 1'b0;
    host_stb = 1'b0;
  endtask

  task automatic host_write(input capture_pkg::buf_addr_t adr,
                            input capture_pkg::cap_data_t data);
    @(negedge rd_clk);
    host_cyc   = 1'b1;
    host_stb   = 1'b1;
    host_we    = 1'b1;
    host_adr   = adr;
    host_dat_w = data;
    wait_host_ack("write", adr);
    host_cyc = 1'b0;
    host_stb = 1'b0;
    host_we  = 1'b0;
  endtask

  task automatic wait_idle();
    repeat (5) @(negedge rd_clk); // empty falls 2 to 3 rd_clk cycles after a write.
    while (chan_idle != 2'b11) begin
      @(negedge rd_clk);
    end
  endtask

  task automatic check_buffer();
    capture_pkg::cap_data_t rdata;
    for (int a = 0; a < `CAP_BUF_WORDS; a++) begin
      if (written[a]) begin
        host_read(capture_pkg::buf_addr_t'(a), rdata);
        expect_word($sformatf("host_dat_r[%0d]", a), rdata, model[a]);
      end
    end
  endtask

  task automatic after_reset();
    expect_word("wr0_full", wr0_full, 16'h0);
    expect_word("wr0_afull", wr0_afull, 16'h0);
    expect_word("wr1_full", wr1_full, 16'h0);
    expect_word("wr1_afull", wr1_afull, 16'h0);
    expect_word("chan_idle", chan_idle, 16'h3);
  endtask

  task automatic single_sample();
    capture_pkg::cap_data_t s0;
    capture_pkg::cap_data_t s1;
    capture_pkg::cap_data_t rdata;
    bit                     ok;
    s0 = next_sample();
    s1 = next_sample();
    push(0, s0, 1'b1, ok);
    push(1, s1, 1'b1, ok);
    wait_idle();
    host_read(6'd0, rdata);
    expect_word("host_dat_r[0]", rdata, s0);
    host_read(6'd32, rdata);
    expect_word("host_dat_r[32]", rdata, s1);
  endtask

  task automatic full_and_afull();
    capture_pkg::cap_data_t words [16];
    capture_pkg::cap_data_t extra;
    capture_pkg::cap_data_t rdata;
    bit                     ok;
    @(negedge rd_clk);
    drain_en[0] = 1'b0;
    for (int i = 0; i < 16; i++) begin
      words[i] = next_sample();
      push(0, words[i], 1'b0, ok);
      checks++;
      if (!ok) begin
        errors++;
        $display("push %0d on channel 0 was refused before the FIFO was full", i);
      end
      expect_word("wr0_afull", wr0_afull, 16'(i >= 14)); // high from the 15th word.
      expect_word("wr0_full", wr0_full, 16'(i == 15));
    end
    extra = next_sample();
    push(0, extra, 1'b0, ok);
    checks++;
    if (ok) begin
      errors++;
      $display("a push on channel 0 was taken while the FIFO was full");
    end
    @(negedge rd_clk);
    drain_en[0] = 1'b1;
    wait_idle();
    for (int a = 0; a < REGION; a++) begin
      host_read(capture_pkg::buf_addr_t'(a), rdata);
      if (a >= 1 && a <= 16) begin
        expect_word($sformatf("host_dat_r[%0d]", a), rdata, words[a-1]);
      end
      checks++;
      if (rdata === extra) begin
        errors++;
        $display("the dropped sample shows up at buffer address %0d", a);
      end
    end
  endtask

  task automatic concurrent_traffic();
    capture_pkg::cap_data_t s0 [20];
    capture_pkg::cap_data_t s1 [20];
    capture_pkg::cap_data_t rdata;
    bit                     ok0;
    bit                     ok1;
    for (int i = 0; i < 20; i++) begin
      s0[i] = next_sample();
      s1[i] = next_sample();
    end
    fork
      begin
        for (int i = 0; i < 20; i++) push(0, s0[i], 1'b1, ok0);
      end
      begin
        for (int i = 0; i < 20; i++) push(1, s1[i], 1'b1, ok1);
      end
      begin
        for (int i = 0; i < 40; i++) begin
          host_read(6'd40, rdata); // each read checks its own ack.
        end
      end
    join
    wait_idle();
    check_buffer();
  endtask

  task automatic region_wrap();
    bit ok;
    // channel 1 sits at offset 21, so 14 more samples wrap to 32..34.
    repeat (14) push(1, next_sample(), 1'b1, ok);
    wait_idle();
    check_buffer();
  endtask

  task automatic host_readback();
    capture_pkg::cap_data_t value;
    capture_pkg::cap_data_t rdata;
    value = next_sample();
    host_write(6'd20, value);
    host_read(6'd20, rdata);
    expect_word("host_dat_r[20]", rdata, value);
    model[20] = value;
    check_buffer();
  endtask

  initial begin
    lfsr       = 16'd7;
    errors     = 0;
    checks     = 0;
    wr0_en     = 1'b0;
    wr1_en     = 1'b0;
    wr0_data   = '0;
    wr1_data   = '0;
    drain_en   = 2'b11;
    host_cyc   = 1'b0;
    host_stb   = 1'b0;
    host_we    = 1'b0;
    host_adr   = '0;
    host_dat_w = '0;
    exp_off[0] = '0;
    exp_off[1] = '0;
    for (int a = 0; a < `CAP_BUF_WORDS; a++) begin
      written[a] = 1'b0;
    end
    wait (rd_rst_n && wr_rst_n);
    @(negedge rd_clk);
    after_reset();
    single_sample();
    full_and_afull();
    concurrent_traffic();
    region_wrap();
    host_readback();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic rd_clk,
  output logic wr_clk,
  output logic rd_rst_n,
  output logic wr_rst_n
);

  initial begin
    rd_clk = 1'b0;
    forever #4 rd_clk = ~rd_clk; // 8 ns period.
  end

  initial begin
    wr_clk = 1'b0;
    forever #5 wr_clk = ~wr_clk; // 10 ns period.
  end

  initial begin
    rd_rst_n = 1'b0;
    wr_rst_n = 1'b0;
    repeat (8) @(posedge rd_clk);
    @(negedge rd_clk);
    rd_rst_n = 1'b1; // both domains leave reset together.
    wr_rst_n = 1'b1;
  end

endmodule
